/* design/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes of the supported RV32I groups
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// funct3 of the ALU groups, SR covers both SRL and SRA
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111
`define RV_F3_JALR    3'b000

`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
`define RV_ALU_PASS_B 4'd10

// Nine control-transfer codes, so the code is four bits wide
`define RV_BR_NONE    4'd0
`define RV_BR_EQ      4'd1
`define RV_BR_NE      4'd2
`define RV_BR_LT      4'd3
`define RV_BR_GE      4'd4
`define RV_BR_LTU     4'd5
`define RV_BR_GEU     4'd6
`define RV_BR_JAL     4'd7
`define RV_BR_JALR    4'd8

// Clock edges from an accepted instruction to its retire report
`define RV_PIPE_DEPTH 3

`endif

/* design/rv_pkg.sv */
package rv_pkg;

  // Data, address and instruction word
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // ALU operation, values are the RV_ALU_* macros
  typedef logic [3:0] alu_op_t;

  // Control-transfer code, values are the RV_BR_* macros
  typedef logic [3:0] br_op_t;

endpackage

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  rv_pkg::word_t     instr,
  input  rv_pkg::word_t     pc,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output logic              dx_valid,
  output logic              dx_illegal,
  output rv_pkg::word_t     dx_pc,
  output rv_pkg::reg_addr_t dx_rs1,
  output rv_pkg::reg_addr_t dx_rs2,
  output rv_pkg::word_t     dx_rs1_data,
  output rv_pkg::word_t     dx_rs2_data,
  output rv_pkg::word_t     dx_imm,
  output logic              dx_use_imm,
  output logic              dx_use_pc,
  output rv_pkg::alu_op_t   dx_alu_op,
  output rv_pkg::br_op_t    dx_br_op,
  output rv_pkg::reg_addr_t dx_rd,
  output logic              dx_we
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_b;
  rv_pkg::word_t     imm_u;
  rv_pkg::word_t     imm_j;
  rv_pkg::word_t     imm;
  logic              use_imm;
  logic              use_pc;
  logic              we;
  logic              illegal;
  rv_pkg::alu_op_t   alu_op;
  rv_pkg::br_op_t    br_op;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rd       = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by the register and immediate groups, alt selects SUB or SRA
  function automatic rv_pkg::alu_op_t alu_of_f3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_t op;
    case (f3)
      `RV_F3_ADD:  op = alt ? `RV_ALU_SUB : `RV_ALU_ADD;
      `RV_F3_SLL:  op = `RV_ALU_SLL;
      `RV_F3_SLT:  op = `RV_ALU_SLT;
      `RV_F3_SLTU: op = `RV_ALU_SLTU;
      `RV_F3_XOR:  op = `RV_ALU_XOR;
      `RV_F3_SR:   op = alt ? `RV_ALU_SRA : `RV_ALU_SRL;
      `RV_F3_OR:   op = `RV_ALU_OR;
      default:     op = `RV_ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    imm     = imm_i;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    we      = 1'b0;
    illegal = 1'b0;
    alu_op  = `RV_ALU_ADD;
    br_op   = `RV_BR_NONE;

    case (opcode)
      `RV_OP_LUI: begin
        imm     = imm_u;
        use_imm = 1'b1;
        we      = 1'b1;
        alu_op  = `RV_ALU_PASS_B;
      end
      `RV_OP_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        we      = 1'b1;
      end
      `RV_OP_JAL: begin
        imm   = imm_j;
        we    = 1'b1;
        br_op = `RV_BR_JAL;
      end
      `RV_OP_JALR: begin
        use_imm = 1'b1;
        we      = 1'b1;
        br_op   = `RV_BR_JALR;
        illegal = (funct3 != `RV_F3_JALR);
      end
      `RV_OP_BRANCH: begin
        imm = imm_b;
        case (funct3)
          `RV_F3_BEQ:  br_op = `RV_BR_EQ;
          `RV_F3_BNE:  br_op = `RV_BR_NE;
          `RV_F3_BLT:  br_op = `RV_BR_LT;
          `RV_F3_BGE:  br_op = `RV_BR_GE;
          `RV_F3_BLTU: br_op = `RV_BR_LTU;
          `RV_F3_BGEU: br_op = `RV_BR_GEU;
          default:     illegal = 1'b1;
        endcase
      end
      `RV_OP_IMM: begin
        use_imm = 1'b1;
        we      = 1'b1;
        // ADDI has no SUB form, funct7 only matters for the shifts
        alu_op  = alu_of_f3(funct3, (funct3 == `RV_F3_SR) && (funct7 == `RV_F7_ALT));
        if (funct3 == `RV_F3_SLL) begin
          illegal = (funct7 != `RV_F7_BASE);
        end else if (funct3 == `RV_F3_SR) begin
          illegal = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
        end
      end
      `RV_OP_REG: begin
        we      = 1'b1;
        alu_op  = alu_of_f3(funct3, funct7 == `RV_F7_ALT);
        illegal = !((funct7 == `RV_F7_BASE) ||
                    ((funct7 == `RV_F7_ALT) &&
                     ((funct3 == `RV_F3_ADD) || (funct3 == `RV_F3_SR))));
      end
      default: illegal = 1'b1;
    endcase

    // An illegal instruction writes nothing and falls through to pc+4
    if (illegal) begin
      we    = 1'b0;
      br_op = `RV_BR_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dx_valid   <= 1'b0;
      dx_illegal <= 1'b0;
      dx_we      <= 1'b0;
    end else begin
      dx_valid   <= instr_valid;
      dx_illegal <= instr_valid && illegal;
      dx_we      <= instr_valid && we && (rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    dx_pc       <= pc;
    dx_rs1      <= rs1_addr;
    dx_rs2      <= rs2_addr;
    dx_rs1_data <= rs1_data;
    dx_rs2_data <= rs2_data;
    dx_imm      <= imm;
    dx_use_imm  <= use_imm;
    dx_use_pc   <= use_pc;
    dx_alu_op   <= alu_op;
    dx_br_op    <= br_op;
    dx_rd       <= rd;
  end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute (
  input  logic              clk,
  input  logic              rst,
  input  logic              dx_valid,
  input  logic              dx_illegal,
  input  rv_pkg::word_t     dx_pc,
  input  rv_pkg::reg_addr_t dx_rs1,
  input  rv_pkg::reg_addr_t dx_rs2,
  input  rv_pkg::word_t     dx_rs1_data,
  input  rv_pkg::word_t     dx_rs2_data,
  input  rv_pkg::word_t     dx_imm,
  input  logic              dx_use_imm,
  input  logic              dx_use_pc,
  input  rv_pkg::alu_op_t   dx_alu_op,
  input  rv_pkg::br_op_t    dx_br_op,
  input  rv_pkg::reg_addr_t dx_rd,
  input  logic              dx_we,
  output logic              xr_valid,
  output logic              xr_illegal,
  output rv_pkg::word_t     xr_pc,
  output logic              xr_we,
  output rv_pkg::reg_addr_t xr_rd,
  output rv_pkg::word_t     xr_data,
  output rv_pkg::word_t     xr_next_pc
);

  rv_pkg::word_t rs1_val;
  rv_pkg::word_t rs2_val;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_res;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t target;
  logic [4:0]    shamt;
  logic          taken;
  logic          jump;

  // xr_we is only set for a valid instruction with a nonzero rd
  assign rs1_val = (xr_we && (xr_rd == dx_rs1)) ? xr_data : dx_rs1_data;
  assign rs2_val = (xr_we && (xr_rd == dx_rs2)) ? xr_data : dx_rs2_data;

  assign alu_a = dx_use_pc ? dx_pc : rs1_val;
  assign alu_b = dx_use_imm ? dx_imm : rs2_val;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (dx_alu_op)
      `RV_ALU_ADD:    alu_res = alu_a + alu_b;
      `RV_ALU_SUB:    alu_res = alu_a - alu_b;
      `RV_ALU_SLL:    alu_res = alu_a << shamt;
      `RV_ALU_SLT:    alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
      `RV_ALU_SLTU:   alu_res = {31'b0, alu_a < alu_b};
      `RV_ALU_XOR:    alu_res = alu_a ^ alu_b;
      `RV_ALU_SRL:    alu_res = alu_a >> shamt;
      `RV_ALU_SRA:    alu_res = $unsigned($signed(alu_a) >>> shamt);
      `RV_ALU_OR:     alu_res = alu_a | alu_b;
      `RV_ALU_AND:    alu_res = alu_a & alu_b;
      `RV_ALU_PASS_B: alu_res = alu_b;
      default:        alu_res = alu_a + alu_b;
    endcase
  end

  always_comb begin
    case (dx_br_op)
      `RV_BR_EQ:   taken = (rs1_val == rs2_val);
      `RV_BR_NE:   taken = (rs1_val != rs2_val);
      `RV_BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
      `RV_BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
      `RV_BR_LTU:  taken = (rs1_val < rs2_val);
      `RV_BR_GEU:  taken = (rs1_val >= rs2_val);
      `RV_BR_JAL:  taken = 1'b1;
      `RV_BR_JALR: taken = 1'b1;
      default:     taken = 1'b0;
    endcase
  end

  assign jump     = (dx_br_op == `RV_BR_JAL) || (dx_br_op == `RV_BR_JALR);
  assign pc_plus4 = dx_pc + 32'd4;

  // JALR takes rs1+imm from the ALU, everything else is pc-relative
  assign target = (dx_br_op == `RV_BR_JALR) ? {alu_res[31:1], 1'b0} : dx_pc + dx_imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      xr_valid   <= 1'b0;
      xr_illegal <= 1'b0;
      xr_we      <= 1'b0;
    end else begin
      xr_valid   <= dx_valid;
      xr_illegal <= dx_illegal;
      xr_we      <= dx_we;
    end
  end

  always_ff @(posedge clk) begin
    xr_pc      <= dx_pc;
    xr_rd      <= dx_rd;
    xr_data    <= jump ? pc_plus4 : alu_res;
    xr_next_pc <= taken ? target : pc_plus4;
  end

endmodule

/* design/rv_result.sv */
`timescale 1ns/1ps

module rv_result (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  logic              xr_valid,
  input  logic              xr_illegal,
  input  rv_pkg::word_t     xr_pc,
  input  logic              xr_we,
  input  rv_pkg::reg_addr_t xr_rd,
  input  rv_pkg::word_t     xr_data,
  input  rv_pkg::word_t     xr_next_pc,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output logic              retire_illegal,
  output logic              retire_we,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data,
  output rv_pkg::word_t     retire_next_pc
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];
  logic          wr_en;

  assign wr_en = xr_valid && xr_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[xr_rd] <= xr_data;
    end
  end

  // A read of the register written at this edge sees the new value
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else if (wr_en && (xr_rd == rs1_addr)) begin
      rs1_data = xr_data;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else if (wr_en && (xr_rd == rs2_addr)) begin
      rs2_data = xr_data;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid   <= 1'b0;
      retire_illegal <= 1'b0;
      retire_we      <= 1'b0;
    end else begin
      retire_valid   <= xr_valid;
      retire_illegal <= xr_valid && xr_illegal;
      retire_we      <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc      <= xr_pc;
    retire_rd      <= xr_rd;
    retire_data    <= xr_data;
    retire_next_pc <= xr_next_pc;
  end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  rv_pkg::word_t     instr,
  input  rv_pkg::word_t     pc,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output logic              retire_illegal,
  output logic              retire_we,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data,
  output rv_pkg::word_t     retire_next_pc
);

  // Register file read ports
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  // Decode register
  logic              dx_valid;
  logic              dx_illegal;
  rv_pkg::word_t     dx_pc;
  rv_pkg::reg_addr_t dx_rs1;
  rv_pkg::reg_addr_t dx_rs2;
  rv_pkg::word_t     dx_rs1_data;
  rv_pkg::word_t     dx_rs2_data;
  rv_pkg::word_t     dx_imm;
  logic              dx_use_imm;
  logic              dx_use_pc;
  rv_pkg::alu_op_t   dx_alu_op;
  rv_pkg::br_op_t    dx_br_op;
  rv_pkg::reg_addr_t dx_rd;
  logic              dx_we;

  // Execute register
  logic              xr_valid;
  logic              xr_illegal;
  rv_pkg::word_t     xr_pc;
  logic              xr_we;
  rv_pkg::reg_addr_t xr_rd;
  rv_pkg::word_t     xr_data;
  rv_pkg::word_t     xr_next_pc;

  // Port names match the stage signals one to one
  rv_decode rv_decode_inst (
    .*
  );

  rv_execute rv_execute_inst (
    .*
  );

  rv_result rv_result_inst (
    .*
  );

endmodule

/* dv/rv_core_properties.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_properties (
  input logic              clk,
  input logic              rst,
  input logic              instr_valid,
  input logic              retire_valid,
  input logic              retire_illegal,
  input logic              retire_we,
  input rv_pkg::reg_addr_t retire_rd
);

  // Fixed latency both ways: every strobe retires and every idle slot stays idle
  latency_a: assert property (@(posedge clk) disable iff (rst)
    retire_valid == $past(instr_valid && !rst, `RV_PIPE_DEPTH))
    else $error("retire_valid does not follow instr_valid by the pipeline depth");

  we_rd_a: assert property (@(posedge clk) disable iff (rst)
    retire_we |-> (retire_rd != 5'd0))
    else $error("retire_we is high for a write to x0");

  we_illegal_a: assert property (@(posedge clk) disable iff (rst)
    retire_we |-> !retire_illegal)
    else $error("retire_we is high for an illegal instruction");

  illegal_valid_a: assert property (@(posedge clk) disable iff (rst)
    retire_illegal |-> retire_valid)
    else $error("retire_illegal is high without retire_valid");

  reset_quiet_a: assert property (@(posedge clk)
    rst |=> !retire_valid)
    else $error("retire_valid is high after a reset edge");

endmodule

bind rv_core rv_core_properties rv_core_properties_inst (
  .clk            (clk),
  .rst            (rst),
  .instr_valid    (instr_valid),
  .retire_valid   (retire_valid),
  .retire_illegal (retire_illegal),
  .retire_we      (retire_we),
  .retire_rd      (retire_rd)
);

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

  localparam int NUM_INSTR = 2000;

  typedef struct packed {
    logic [2:0]        cls;
    logic [31:0]       issued_at;
    rv_pkg::word_t     pc;
    logic              illegal;
    logic              we;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;
    rv_pkg::word_t     next_pc;
  } retire_rec_t;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  rv_pkg::word_t     instr;
  rv_pkg::word_t     pc;
  logic              retire_valid;
  rv_pkg::word_t     retire_pc;
  logic              retire_illegal;
  logic              retire_we;
  rv_pkg::reg_addr_t retire_rd;
  rv_pkg::word_t     retire_data;
  rv_pkg::word_t     retire_next_pc;

  logic [31:0]   lfsr;
  rv_pkg::word_t cur_pc;
  rv_pkg::word_t ref_regs [0:31];
  retire_rec_t   exp_q [$];
  int            edges;

  rv_core rv_core_inst (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_illegal (retire_illegal),
    .retire_we      (retire_we),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_next_pc (retire_next_pc)
  );

  always #4 clk = ~clk;

  always @(posedge clk) edges <= edges + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Mostly x1 to x7 so that neighbours depend on each other
  function automatic rv_pkg::reg_addr_t pick_reg();
    logic [2:0] sel;
    sel = 3'(take_bits(3));
    if (sel == 3'd0) return 5'd0;
    if (sel == 3'd1) return 5'(take_bits(5));
    return 5'(take_bits(3) % 7 + 1);
  endfunction

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = {31'd0, $signed(a) < $signed(b)};
      3'd3:    r = {31'd0, a < b};
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a,
                                      input rv_pkg::word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic string class_name(input logic [2:0] c);
    case (c)
      3'd0:    return "alu_reg";
      3'd1:    return "alu_imm";
      3'd2:    return "branch";
      3'd3:    return "lui";
      3'd4:    return "auipc";
      3'd5:    return "jal";
      3'd6:    return "jalr";
      default: return "illegal";
    endcase
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_word(input string test, input string field,
                              input rv_pkg::word_t expected, input rv_pkg::word_t actual);
    assert (actual == expected) else
      stop_run($sformatf("Mismatch %s %s: expected %h, actual %h",
                         test, field, expected, actual));
  endtask

  // Reset flushes the pipeline and clears the register file, and the model follows
  task automatic apply_reset();
    rst = 1'b1;
    instr_valid = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
  endtask

  // Retire ports are registered, so they are stable at the falling edge
  task automatic check_retire();
    retire_rec_t e;
    string       name;
    if (retire_valid) begin
      assert (exp_q.size() > 0) else
        stop_run("A retire report arrived with no instruction in flight");
      e = exp_q.pop_front();
      name = class_name(e.cls);
      compare_word(name, "latency", 32'(`RV_PIPE_DEPTH), 32'(edges) - e.issued_at);
      compare_word(name, "pc", e.pc, retire_pc);
      compare_word(name, "illegal", 32'(e.illegal), 32'(retire_illegal));
      compare_word(name, "we", 32'(e.we), 32'(retire_we));
      compare_word(name, "rd", 32'(e.rd), 32'(retire_rd));
      compare_word(name, "next_pc", e.next_pc, retire_next_pc);
      if (e.we) begin
        compare_word(name, "data", e.data, retire_data);
      end
    end
  endtask

  // Builds one instruction, predicts its retire record and drives it
  task automatic issue_one();
    logic [3:0]        sel;
    logic [2:0]        f3;
    logic              alt;
    logic              writes;
    logic              illegal;
    logic [11:0]       imm12;
    logic [12:0]       imm13;
    logic [19:0]       imm20;
    logic [20:0]       imm21;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::word_t     word;
    rv_pkg::word_t     data;
    rv_pkg::word_t     next_pc;
    retire_rec_t       rec;
    sel = 4'(take_bits(4));
    rd = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3 = 3'(take_bits(3));
    alt = 1'(take_bits(1));
    imm12 = 12'(take_bits(12));
    imm20 = 20'(take_bits(20));
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    writes = 1'b1;
    illegal = 1'b0;
    data = '0;
    next_pc = cur_pc + 32'd4;
    if (sel < 4'd4) begin
      rec.cls = 3'd0;
      alt = alt && ((f3 == 3'd0) || (f3 == 3'd5));
      word = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, `RV_OP_REG};
      data = alu_ref(f3, alt, a, b);
    end else if (sel < 4'd7) begin
      rec.cls = 3'd1;
      if (f3 == 3'd1) imm12 = {7'b0000000, imm12[4:0]};
      if (f3 == 3'd5) imm12 = {1'b0, alt, 5'b00000, imm12[4:0]};
      word = {imm12, rs1, f3, rd, `RV_OP_IMM};
      data = alu_ref(f3, (f3 == 3'd5) && alt, a, {{20{imm12[11]}}, imm12});
    end else if (sel < 4'd10) begin
      rec.cls = 3'd2;
      writes = 1'b0;
      if ((f3 == 3'd2) || (f3 == 3'd3)) f3 = f3 + 3'd4;
      imm13 = {imm12, 1'b0};
      word = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], `RV_OP_BRANCH};
      if (branch_ref(f3, a, b)) next_pc = cur_pc + {{19{imm13[12]}}, imm13};
    end else if (sel == 4'd10) begin
      rec.cls = 3'd3;
      word = {imm20, rd, `RV_OP_LUI};
      data = {imm20, 12'h000};
    end else if (sel == 4'd11) begin
      rec.cls = 3'd4;
      word = {imm20, rd, `RV_OP_AUIPC};
      data = cur_pc + {imm20, 12'h000};
    end else if (sel == 4'd12) begin
      rec.cls = 3'd5;
      imm21 = {imm20, 1'b0};
      word = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, `RV_OP_JAL};
      data = cur_pc + 32'd4;
      next_pc = cur_pc + {{11{imm21[20]}}, imm21};
    end else if (sel == 4'd13) begin
      rec.cls = 3'd6;
      word = {imm12, rs1, 3'b000, rd, `RV_OP_JALR};
      data = cur_pc + 32'd4;
      next_pc = (a + {{20{imm12[11]}}, imm12}) & ~32'd1;
    end else begin
      // Loads, stores, system, M extension, bad funct3, FENCE and compressed
      rec.cls = 3'd7;
      writes = 1'b0;
      illegal = 1'b1;
      word = take_bits(32);
      case (3'(take_bits(3)))
        3'd0: word[6:0] = 7'b0000011;
        3'd1: word[6:0] = 7'b0100011;
        3'd2: word = 32'h00000073;
        3'd3: word = {7'b0000001, rs2, rs1, f3, rd, `RV_OP_REG};
        3'd4: word = {word[31:15], 2'b01, f3[0], word[11:7], `RV_OP_BRANCH};
        3'd5: word = {word[31:15], (f3 == 3'd0) ? 3'd4 : f3, word[11:7], `RV_OP_JALR};
        3'd6: word[6:0] = 7'b0001111;
        default: word[1:0] = 2'b00;
      endcase
    end
    rec.issued_at = 32'(edges);
    rec.pc = cur_pc;
    rec.illegal = illegal;
    rec.rd = word[11:7];
    rec.we = writes && (word[11:7] != 5'd0);
    rec.data = data;
    rec.next_pc = next_pc;
    if (rec.we) ref_regs[rec.rd] = data;
    exp_q.push_back(rec);
    instr_valid = 1'b1;
    instr = word;
    pc = cur_pc;
    cur_pc = cur_pc + 32'd4;
  endtask

  initial begin
    int   issued;
    int   cycles;
    int   idle;
    logic midrun_reset_done;
    clk = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    edges = 0;
    lfsr = 32'he5b9;
    cur_pc = 32'h0000_1000;
    apply_reset();
    issued = 0;
    cycles = 0;
    midrun_reset_done = 1'b0;
    while (issued < NUM_INSTR) begin
      @(negedge clk);
      check_retire();
      if ((issued == NUM_INSTR / 2) && !midrun_reset_done) begin
        // The last instructions are still in the pipeline when reset hits
        apply_reset();
        midrun_reset_done = 1'b1;
      end else if (take_bits(2) == 32'd0) begin
        instr_valid = 1'b0;
      end else begin
        issue_one();
        issued++;
      end
      cycles++;
      if (cycles > 4 * NUM_INSTR) stop_run("Issue loop ran past its cycle budget");
    end
    idle = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      instr_valid = 1'b0;
      check_retire();
      idle++;
      if (idle > 4 * `RV_PIPE_DEPTH) stop_run("Issued instructions did not all retire in time");
    end
    // A few quiet cycles catch any retire report beyond the last instruction
    for (int i = 0; i < 2 * `RV_PIPE_DEPTH; i++) begin
      @(negedge clk);
      check_retire();
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/rv_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f compile.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

exit 0
